//--- filelist.f
+incdir+include
source/cpu_pkg.sv
source/pipe_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/cpu_core.sv
verification/cpu_asserts.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

//--- include/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data path and address width
`define CPU_BITS 16

// stack pointer width, gives 16 return slots
`define CPU_STACK_BITS 4

// register id width, gives 256 registers
`define CPU_REG_ID_BITS 8

// instruction word spans two data words
`define CPU_INSTR_BITS (2 * `CPU_BITS)

`endif

//--- run_sim.sh
#!/bin/sh
# build the cpu testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module cpu_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vcpu_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$log"; then
    exit 0
fi
echo "simulation failed, see $log"
exit 1

//--- source/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_core (
    input  logic                       clk,
    input  logic                       reset,
    output logic [`CPU_BITS-1:0]       instr_addr,
    input  logic [`CPU_INSTR_BITS-1:0] instr_data,
    input  logic [`CPU_BITS-1:0]       io_data_in,
    output logic                       io_rd,
    output logic                       io_wr,
    output logic [`CPU_BITS-1:0]       io_data_out,
    output logic                       hlt
);
    logic                        fetch_valid;
    cpu_pkg::instr_u             fetch_instr;
    logic [`CPU_BITS-1:0]        fetch_pc;
    logic                        stall;
    logic                        redirect;
    logic [`CPU_BITS-1:0]        redirect_addr;
    logic                        carry;
    logic                        zero;
    logic                        alu_busy;
    logic                        wb_en;
    logic [`CPU_REG_ID_BITS-1:0] wb_id;
    logic [`CPU_BITS-1:0]        wb_data;

    issue_if  i_issue ();
    result_if i_result ();

    fetch_stage i_fetch (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .redirect(redirect),
        .redirect_addr(redirect_addr),
        .halted(hlt),
        .instr_data(instr_data),
        .instr_addr(instr_addr),
        .fetch_valid(fetch_valid),
        .fetch_instr(fetch_instr),
        .fetch_pc(fetch_pc)
    );

    decode_stage i_decode (
        .clk(clk),
        .reset(reset),
        .fetch_valid(fetch_valid),
        .fetch_instr(fetch_instr),
        .fetch_pc(fetch_pc),
        .carry(carry),
        .zero(zero),
        .alu_busy(alu_busy),
        .wb_en(wb_en),
        .wb_id(wb_id),
        .wb_data(wb_data),
        .issue(i_issue.source),
        .stall(stall),
        .redirect(redirect),
        .redirect_addr(redirect_addr),
        .hlt(hlt)
    );

    execute_stage i_execute (
        .clk(clk),
        .reset(reset),
        .issue(i_issue.sink),
        .io_data_in(io_data_in),
        .io_rd(io_rd),
        .carry(carry),
        .zero(zero),
        .alu_busy(alu_busy),
        .result(i_result.source)
    );

    writeback_stage i_writeback (
        .clk(clk),
        .reset(reset),
        .result(i_result.sink),
        .wb_en(wb_en),
        .wb_id(wb_id),
        .wb_data(wb_data),
        .io_wr(io_wr),
        .io_data_out(io_data_out)
    );

endmodule

//--- source/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef enum logic [2:0] {
        cls_control    = 3'd0,
        cls_alu_reg    = 3'd1,
        cls_alu_imm    = 3'd2,
        cls_alu_io_in  = 3'd3,
        cls_alu_io_out = 3'd4
    } instr_class_e;

    typedef enum logic [4:0] {
        alu_nop  = 5'h00,
        alu_add  = 5'h01,
        alu_adc  = 5'h02,
        alu_sub  = 5'h03,
        alu_and  = 5'h04,
        alu_or   = 5'h05,
        alu_xor  = 5'h06,
        alu_shl  = 5'h07,
        alu_shr  = 5'h08,
        alu_pass = 5'h09
    } alu_op_e;

    // class 0 reuses the op field for these
    typedef enum logic [4:0] {
        ctl_nop   = 5'h00,
        ctl_jmp   = 5'h01,
        ctl_jc    = 5'h02,
        ctl_jz    = 5'h03,
        ctl_jr    = 5'h04,
        ctl_call  = 5'h09,
        ctl_callc = 5'h0a,
        ctl_callz = 5'h0b,
        ctl_ret   = 5'h11,
        ctl_retc  = 5'h12,
        ctl_retz  = 5'h13,
        ctl_hlt   = 5'h1f
    } ctrl_op_e;

    typedef struct packed {
        logic [`CPU_REG_ID_BITS-1:0] id1;
        logic [`CPU_REG_ID_BITS-1:0] id2;
        logic [`CPU_REG_ID_BITS-1:0] id3;
        instr_class_e                cls;
        logic [4:0]                  op;
    } reg_form_t;

    typedef struct packed {
        logic [`CPU_BITS-1:0]        imm;
        logic [`CPU_REG_ID_BITS-1:0] id3;
        instr_class_e                cls;
        logic [4:0]                  op;
    } imm_form_t;

    typedef union packed {
        reg_form_t reg_form;
        imm_form_t imm_form;
    } instr_u;

endpackage

//--- source/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module decode_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        fetch_valid,
    input  cpu_pkg::instr_u             fetch_instr,
    input  logic [`CPU_BITS-1:0]        fetch_pc,
    input  logic                        carry,
    input  logic                        zero,
    input  logic                        alu_busy,
    input  logic                        wb_en,
    input  logic [`CPU_REG_ID_BITS-1:0] wb_id,
    input  logic [`CPU_BITS-1:0]        wb_data,
    issue_if.source                     issue,
    output logic                        stall,
    output logic                        redirect,
    output logic [`CPU_BITS-1:0]        redirect_addr,
    output logic                        hlt
);
    logic [`CPU_BITS-1:0] regs [0:(1 << `CPU_REG_ID_BITS) - 1];
    logic [`CPU_BITS-1:0] stack [0:(1 << `CPU_STACK_BITS) - 1];
    logic [`CPU_STACK_BITS-1:0] sp;
    logic wb_io;

    cpu_pkg::instr_class_e cls;
    logic [4:0] op;
    logic [`CPU_REG_ID_BITS-1:0] id1;
    logic [`CPU_REG_ID_BITS-1:0] id2;
    logic [`CPU_REG_ID_BITS-1:0] id3;
    logic [`CPU_BITS-1:0] rf_a;
    logic [`CPU_BITS-1:0] rf_b;
    logic [`CPU_BITS-1:0] rf_c;
    logic [`CPU_BITS-1:0] op1_sel;
    logic [`CPU_BITS-1:0] op2_sel;
    logic alu_class;
    logic is_hlt;
    logic cond;
    logic taken;
    logic push_c;
    logic pop_c;
    logic push;
    logic pop;
    logic ex_writes;
    logic hit_a;
    logic hit_b;
    logic hit_c;
    logic use_c;
    logic io_clash;
    logic hazard;
    logic go;

    assign cls = fetch_instr.reg_form.cls;
    assign op = fetch_instr.reg_form.op;
    assign id1 = fetch_instr.reg_form.id1;
    assign id2 = fetch_instr.reg_form.id2;
    assign id3 = fetch_instr.reg_form.id3;

    // write-through read ports
    assign rf_a = (wb_en && wb_id == id1) ? wb_data : regs[id1];
    assign rf_b = (wb_en && wb_id == id2) ? wb_data : regs[id2];
    assign rf_c = (wb_en && wb_id == id3) ? wb_data : regs[id3];

    assign alu_class = cls inside {cpu_pkg::cls_alu_reg, cpu_pkg::cls_alu_imm,
                                   cpu_pkg::cls_alu_io_in, cpu_pkg::cls_alu_io_out};
    assign is_hlt = cls == cpu_pkg::cls_control && op == cpu_pkg::ctl_hlt;

    always_comb begin
        taken = 1'b0;
        cond = 1'b0;
        push_c = 1'b0;
        pop_c = 1'b0;
        redirect_addr = fetch_instr.imm_form.imm;
        if (cls == cpu_pkg::cls_control) begin
            case (cpu_pkg::ctrl_op_e'(op))
                cpu_pkg::ctl_jmp: taken = 1'b1;
                cpu_pkg::ctl_jc: begin
                    cond = 1'b1;
                    taken = carry;
                end
                cpu_pkg::ctl_jz: begin
                    cond = 1'b1;
                    taken = zero;
                end
                cpu_pkg::ctl_jr: begin
                    taken = 1'b1;
                    redirect_addr = rf_c;
                end
                cpu_pkg::ctl_call: begin
                    taken = 1'b1;
                    push_c = 1'b1;
                end
                cpu_pkg::ctl_callc, cpu_pkg::ctl_callz: begin
                    cond = 1'b1;
                    taken = (op == cpu_pkg::ctl_callc) ? carry : zero;
                    push_c = taken;
                end
                cpu_pkg::ctl_ret, cpu_pkg::ctl_retc, cpu_pkg::ctl_retz: begin
                    cond = op != cpu_pkg::ctl_ret;
                    taken = !cond || ((op == cpu_pkg::ctl_retc) ? carry : zero);
                    pop_c = taken;
                    redirect_addr = stack[sp];
                end
                // park fetch on the halt word itself
                cpu_pkg::ctl_hlt: begin
                    taken = 1'b1;
                    redirect_addr = fetch_pc;
                end
                default: taken = 1'b0;
            endcase
        end
    end

    // scoreboard: execute from our own issue regs, writeback from its write port
    assign ex_writes = issue.valid && issue.writes_reg;
    assign hit_a = (ex_writes && issue.dest == id1) || (wb_en && wb_id == id1);
    assign hit_b = (ex_writes && issue.dest == id2) || (wb_en && wb_id == id2);
    assign hit_c = (ex_writes && issue.dest == id3) || (wb_en && wb_id == id3);
    assign use_c = (alu_class && cls != cpu_pkg::cls_alu_reg) ||
                   (cls == cpu_pkg::cls_control && op == cpu_pkg::ctl_jr);

    // keeps io_rd and io_wr pulses apart from each other
    assign io_clash = (cls == cpu_pkg::cls_alu_io_out && issue.valid && issue.writes_io) ||
                      (cls == cpu_pkg::cls_alu_io_in &&
                       ((issue.valid && issue.cls == cpu_pkg::cls_alu_io_in) || wb_io));

    assign hazard = (cls == cpu_pkg::cls_alu_reg && (hit_a || hit_b)) ||
                    (use_c && hit_c) || io_clash || ((cond || is_hlt) && alu_busy);
    assign stall = fetch_valid && !hlt && hazard;
    assign go = fetch_valid && !hlt && !hazard;
    assign redirect = go && taken;
    assign push = go && push_c;
    assign pop = go && pop_c;

    always_comb begin
        op1_sel = rf_c;
        op2_sel = rf_c;
        if (cls == cpu_pkg::cls_alu_reg) begin
            op1_sel = rf_b;
            op2_sel = rf_a;
        end else if (cls == cpu_pkg::cls_alu_imm) begin
            op1_sel = fetch_instr.imm_form.imm;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en)
            regs[wb_id] <= wb_data;
        // predecrement on call
        if (push)
            stack[sp - 1'b1] <= fetch_pc + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            sp <= '0;
            hlt <= 1'b0;
            wb_io <= 1'b0;
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= go && alu_class;
            wb_io <= issue.valid && issue.writes_io;
            if (push)
                sp <= sp - 1'b1;
            else if (pop)
                sp <= sp + 1'b1;
            if (go && is_hlt)
                hlt <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            issue.cls <= cls;
            issue.op <= cpu_pkg::alu_op_e'(op);
            issue.op1 <= op1_sel;
            issue.op2 <= op2_sel;
            issue.dest <= id3;
            issue.writes_reg <= cls inside {cpu_pkg::cls_alu_reg, cpu_pkg::cls_alu_imm,
                                            cpu_pkg::cls_alu_io_in};
            issue.writes_io <= cls == cpu_pkg::cls_alu_io_out;
        end
    end

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module execute_stage (
    input  logic                 clk,
    input  logic                 reset,
    issue_if.sink                issue,
    input  logic [`CPU_BITS-1:0] io_data_in,
    output logic                 io_rd,
    output logic                 carry,
    output logic                 zero,
    output logic                 alu_busy,
    result_if.source             result
);
    logic [`CPU_BITS-1:0] a;
    logic [`CPU_BITS-1:0] b;
    logic [`CPU_BITS:0]   sum;
    logic                 io_in;

    assign io_in = issue.valid && issue.cls == cpu_pkg::cls_alu_io_in;
    assign io_rd = !io_in;
    assign a = (issue.cls == cpu_pkg::cls_alu_io_in) ? io_data_in : issue.op1;
    assign b = issue.op2;
    assign alu_busy = issue.valid || result.valid;

    // top bit of sum is the carry out
    always_comb begin
        case (issue.op)
            cpu_pkg::alu_add:  sum = {1'b0, a} + {1'b0, b};
            cpu_pkg::alu_adc:  sum = {1'b0, a} + {1'b0, b} + {{`CPU_BITS{1'b0}}, carry};
            cpu_pkg::alu_sub:  sum = {1'b0, a} - {1'b0, b};
            cpu_pkg::alu_and:  sum = {1'b0, a & b};
            cpu_pkg::alu_or:   sum = {1'b0, a | b};
            cpu_pkg::alu_xor:  sum = {1'b0, a ^ b};
            // shifts act on op2, one bit
            cpu_pkg::alu_shl:  sum = {b, 1'b0};
            cpu_pkg::alu_shr:  sum = {b[0], 1'b0, b[`CPU_BITS-1:1]};
            cpu_pkg::alu_pass: sum = {1'b0, a};
            default:           sum = {1'b0, b};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            carry <= 1'b0;
            zero <= 1'b0;
            result.valid <= 1'b0;
        end else begin
            result.valid <= issue.valid;
            if (issue.valid) begin
                carry <= sum[`CPU_BITS];
                zero <= sum[`CPU_BITS-1:0] == '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            result.value <= sum[`CPU_BITS-1:0];
            result.dest <= issue.dest;
            result.writes_reg <= issue.writes_reg;
            result.writes_io <= issue.writes_io;
        end
    end

endmodule

//--- source/fetch_stage.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module fetch_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  logic                       redirect,
    input  logic [`CPU_BITS-1:0]       redirect_addr,
    input  logic                       halted,
    input  logic [`CPU_INSTR_BITS-1:0] instr_data,
    output logic [`CPU_BITS-1:0]       instr_addr,
    output logic                       fetch_valid,
    output cpu_pkg::instr_u            fetch_instr,
    output logic [`CPU_BITS-1:0]       fetch_pc
);
    logic [`CPU_BITS-1:0] pc;
    logic                 advance;

    assign instr_addr = pc;
    assign advance = !halted && !redirect && !stall;

    always_ff @(posedge clk) begin
        if (!reset) begin
            pc <= '0;
            fetch_valid <= 1'b0;
        end else if (!halted) begin
            // taken branch drops the word fetched behind it
            if (redirect) begin
                pc <= redirect_addr;
                fetch_valid <= 1'b0;
            end else if (!stall) begin
                pc <= pc + 1'b1;
                fetch_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            fetch_instr <= instr_data;
            fetch_pc <= pc;
        end
    end

endmodule

//--- source/pipe_if.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

// decode to execute
interface issue_if;
    logic                        valid;
    cpu_pkg::instr_class_e       cls;
    cpu_pkg::alu_op_e            op;
    logic [`CPU_BITS-1:0]        op1;
    logic [`CPU_BITS-1:0]        op2;
    logic [`CPU_REG_ID_BITS-1:0] dest;
    logic                        writes_reg;
    logic                        writes_io;

    modport source (
        output valid, cls, op, op1, op2, dest, writes_reg, writes_io
    );

    modport sink (
        input valid, cls, op, op1, op2, dest, writes_reg, writes_io
    );
endinterface

// execute to writeback
interface result_if;
    logic                        valid;
    logic [`CPU_BITS-1:0]        value;
    logic [`CPU_REG_ID_BITS-1:0] dest;
    logic                        writes_reg;
    logic                        writes_io;

    modport source (
        output valid, value, dest, writes_reg, writes_io
    );

    modport sink (
        input valid, value, dest, writes_reg, writes_io
    );
endinterface

//--- source/writeback_stage.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module writeback_stage (
    input  logic                        clk,
    input  logic                        reset,
    result_if.sink                      result,
    output logic                        wb_en,
    output logic [`CPU_REG_ID_BITS-1:0] wb_id,
    output logic [`CPU_BITS-1:0]        wb_data,
    output logic                        io_wr,
    output logic [`CPU_BITS-1:0]        io_data_out
);
    logic out_hit;

    // register file is written by decode on these
    assign wb_en = result.valid && result.writes_reg;
    assign wb_id = result.dest;
    assign wb_data = result.value;

    assign out_hit = result.valid && result.writes_io;

    always_ff @(posedge clk) begin
        if (!reset)
            io_wr <= 1'b1;
        else
            io_wr <= !out_hit;
    end

    // data holds after the strobe returns high
    always_ff @(posedge clk) begin
        if (out_hit)
            io_data_out <= result.value;
    end

endmodule

//--- verification/cpu_asserts.sv
`timescale 1ns/1ps

module cpu_asserts (
    input logic clk,
    input logic reset,
    input logic io_rd,
    input logic io_wr,
    input logic hlt
);
    // both strobes are active low
    strobes_apart: assert property (@(posedge clk) disable iff (!reset)
        !(!io_rd && !io_wr))
        else $error("io_rd and io_wr low in the same cycle");

    rd_single: assert property (@(posedge clk) disable iff (!reset) !io_rd |=> io_rd)
        else $error("io_rd low for more than one cycle");

    wr_single: assert property (@(posedge clk) disable iff (!reset) !io_wr |=> io_wr)
        else $error("io_wr low for more than one cycle");

    // only reset clears hlt
    hlt_held: assert property (@(posedge clk) disable iff (!reset) hlt |=> hlt)
        else $error("hlt fell without reset");

endmodule

//--- verification/cpu_checker.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_checker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 io_rd,
    input  logic                 io_wr,
    input  logic [`CPU_BITS-1:0] io_data_out,
    input  logic                 hlt,
    input  logic [`CPU_BITS-1:0] instr_addr,
    input  logic [`CPU_BITS-1:0] expected [0:31],
    input  logic [5:0]           exp_count,
    input  logic [`CPU_BITS-1:0] halt_addr,
    output int                   mismatches,
    output int                   failures,
    output logic                 halt_done
);
    int         mismatch_cnt = 0;
    int         failure_cnt = 0;
    logic [5:0] out_count;

    assign mismatches = mismatch_cnt;
    assign failures = failure_cnt;

    // outputs only change on the rising edge
    always @(negedge clk) begin
        if (!reset) begin
            out_count = 6'd0;
            halt_done <= 1'b0;
            if (!io_rd || !io_wr || hlt) begin
                failure_cnt = failure_cnt + 1;
                $display("outputs not idle in reset: io_rd=%b io_wr=%b hlt=%b",
                         io_rd, io_wr, hlt);
            end
        end else begin
            if (!io_wr) begin
                if (halt_done) begin
                    failure_cnt = failure_cnt + 1;
                    $display("io_wr pulse seen after halt");
                end else if (out_count >= exp_count) begin
                    failure_cnt = failure_cnt + 1;
                    $display("more io_wr pulses than expected, io_data_out %h", io_data_out);
                end else if (io_data_out !== expected[out_count[4:0]]) begin
                    mismatch_cnt = mismatch_cnt + 1;
                    $display("Mismatch io_data_out: got %h, expected %h (output %0d)",
                             io_data_out, expected[out_count[4:0]], out_count);
                end
                out_count = out_count + 6'd1;
            end
            if (hlt && !halt_done) begin
                halt_done <= 1'b1;
                if (out_count != exp_count) begin
                    failure_cnt = failure_cnt + 1;
                    $display("halt reached after %0d outputs, %0d expected",
                             out_count, exp_count);
                end
            end
            if (hlt && instr_addr !== halt_addr) begin
                mismatch_cnt = mismatch_cnt + 1;
                $display("Mismatch instr_addr: got %h, expected %h", instr_addr, halt_addr);
            end
        end
    end

endmodule

//--- verification/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_tb;
    localparam int HALT_TIMEOUT = 2000;
    localparam int AFTER_HALT = 8;

    logic                       clk;
    logic                       reset;
    logic [`CPU_BITS-1:0]       instr_addr;
    logic [`CPU_INSTR_BITS-1:0] instr_data;
    logic [`CPU_BITS-1:0]       io_data_in;
    logic                       io_rd;
    logic                       io_wr;
    logic [`CPU_BITS-1:0]       io_data_out;
    logic                       hlt;

    // image layout: program 00, inputs 80, output count a0, outputs c0, halt address ff
    logic [`CPU_INSTR_BITS-1:0] image [0:255];
    logic [`CPU_INSTR_BITS-1:0] prog [0:127];
    logic [`CPU_BITS-1:0]       inputs [0:7];
    logic [`CPU_BITS-1:0]       expected [0:31];
    logic [5:0]                 exp_count;
    logic [`CPU_BITS-1:0]       halt_addr;

    logic [2:0] in_idx;
    logic       rd_pending;
    int         mismatches;
    int         failures;
    int         timeouts;
    logic       halt_done;

    cpu_core i_cpu_core (
        .clk(clk),
        .reset(reset),
        .instr_addr(instr_addr),
        .instr_data(instr_data),
        .io_data_in(io_data_in),
        .io_rd(io_rd),
        .io_wr(io_wr),
        .io_data_out(io_data_out),
        .hlt(hlt)
    );

    cpu_checker i_checker (
        .clk(clk),
        .reset(reset),
        .io_rd(io_rd),
        .io_wr(io_wr),
        .io_data_out(io_data_out),
        .hlt(hlt),
        .instr_addr(instr_addr),
        .expected(expected),
        .exp_count(exp_count),
        .halt_addr(halt_addr),
        .mismatches(mismatches),
        .failures(failures),
        .halt_done(halt_done)
    );

    bind cpu_core cpu_asserts i_cpu_asserts (
        .clk(clk),
        .reset(reset),
        .io_rd(io_rd),
        .io_wr(io_wr),
        .hlt(hlt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // instruction memory and io device, both answer on the falling edge
    always @(negedge clk) begin
        if (instr_addr[`CPU_BITS-1:7] == '0)
            instr_data <= prog[instr_addr[6:0]];
        else
            instr_data <= '0;
        if (!reset) begin
            in_idx = 3'd0;
            rd_pending = 1'b0;
        end else begin
            if (rd_pending)
                in_idx = in_idx + 3'd1;
            rd_pending = !io_rd;
        end
        io_data_in <= inputs[in_idx];
    end

    initial begin
        logic [7:0] k;
        int         cycles;
        reset = 1'b0;
        instr_data = '0;
        io_data_in = '0;
        in_idx = 3'd0;
        rd_pending = 1'b0;
        timeouts = 0;
        $readmemh("verification/cpu_vectors.txt", image);
        for (k = 8'd0; k < 8'd128; k = k + 8'd1)
            prog[k[6:0]] = image[k];
        for (k = 8'd0; k < 8'd8; k = k + 8'd1)
            inputs[k[2:0]] = image[8'h80 + k][`CPU_BITS-1:0];
        for (k = 8'd0; k < 8'd32; k = k + 8'd1)
            expected[k[4:0]] = image[8'hc0 + k][`CPU_BITS-1:0];
        exp_count = image[8'ha0][5:0];
        halt_addr = image[8'hff][`CPU_BITS-1:0];

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        cycles = 0;
        while (!halt_done && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (!halt_done) begin
            timeouts = timeouts + 1;
            $display("timeout: hlt did not rise within %0d cycles", HALT_TIMEOUT);
        end else begin
            // stay a while to catch late io_wr pulses
            repeat (AFTER_HALT) @(negedge clk);
        end

        $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
                 mismatches, failures, timeouts);
        if (mismatches == 0 && failures == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verification/cpu_vectors.txt
// hex words, several per line in rising address order; @ sets the address
// program at 00, io inputs at 80, output count at a0, expected outputs at c0, halt address at ff
@00
12340149 00ff0249 02010321 00000389  // reg add, dependent output
02010423 00000489 02010524 a0000545  // sub, and, or immediate
00000589 02010626 00000689 01010727  // xor, shl
00000748 20000743 00000789 02020829  // shr, sub immediate, pass
00000889 ffff0949 00010941 00160002  // carry set, jc taken
dead0a49 00000a89 00050141 001a0003  // skipped pair, jz not taken
00000189 00000b49 001d0002 001e0003  // jc not taken, jz taken
00000289 00000a89 00000b89 00400009  // skipped pair, nested call
00000c89 80000e49 00000e47 004c000b  // shl out carry, callz taken
0050000a 010b1023 0054000a 00001089  // callc not taken, borrow, callc taken
00001169 01001249 00001261 12111326  // io reads combined with registers
00001389 00001163 00001189 fff01449
00011549 00201441 14151522 00001589  // adc
00381649 00001604 00000289 00000a89  // jump by register
00001689 0000001f                    // halt at 39
@40
00a10c49 00000c89 00480009 00000d89 00000011
@48
00b20d49 00000d89 00000011
@4c
00c30f49 00000f89 00000013 00000011 00000289 00000011
@54
00001089 00000012 12391041 00000012
@80
00005a5a 00000f0f 00006000
@a0
00000013
@c0
00001333 00001135 0000a034 000012cb 00000dcc 000000ff 00001239 00000000
000000a1 000000b2 000000b2 000000a1 000000c3 0000edc7 00000000 00004a55
000005a6 00000012 00000038
@ff
00000039
